//--- Makefile
# Verilator build and run for the riscCore testbench

TOP = riscCoreTb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f riscCore.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation OK"; \
	fi

lint:
	verilator --lint-only --timing -Wall -f riscCore.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- design/corePkg.sv
// Core widths, memory sizes, opcode and ALU encodings, control, program load and retire records
package corePkg;

  localparam int xlen = 64;
  localparam int regAddrW = 5;
  localparam int imemWords = 64;
  localparam int imemAddrW = 6;
  localparam int dmemWords = 32;
  localparam int dmemAddrW = 5;

  typedef logic [xlen-1:0] wordT;
  typedef logic [31:0] instrT;

  typedef enum logic [6:0] {
    opR      = 7'b0110011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opBranch = 7'b1100011,
    opImm    = 7'b0010011
  } opcodeE;

  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluOr  = 4'b0001,
    aluAdd = 4'b0010,
    aluSub = 4'b0110
  } aluOpE;

  typedef enum logic [1:0] {
    brNone,
    brEq,
    brLt,
    brGe
  } branchE;

  typedef struct packed {
    logic   regWrite;
    logic   memToReg;   // Write back load data
    logic   memWrite;
    logic   aluSrcImm;  // Second operand from imm
    branchE branch;
    aluOpE  aluOp;
  } ctrlT;

  typedef struct packed {
    logic                 valid;
    logic [imemAddrW-1:0] wordAddr;
    instrT                instr;
  } progWriteT;

  typedef struct packed {
    logic                 valid;
    wordT                 pc;
    logic                 rdWrite;
    logic [regAddrW-1:0]  rd;
    wordT                 rdData;
    logic                 store;
    logic [dmemAddrW-1:0] storeAddr;
    wordT                 storeData;
  } retireT;

endpackage

//--- design/dataMemory.sv
// Doubleword data memory with reset clearing, clocked store and combinational load
`timescale 1ns/1ps

module dataMemory (
  input  logic          clk,
  input  logic          reset,
  input  corePkg::wordT aluResult,
  input  corePkg::wordT rs2Data,
  input  corePkg::ctrlT ctrl,
  output corePkg::wordT loadData
);

  corePkg::wordT mem [corePkg::dmemWords];
  logic [corePkg::dmemAddrW-1:0] dAddr;

  // Byte offset ignored, index wraps over 32 doublewords
  assign dAddr = aluResult[corePkg::dmemAddrW+2:3];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < corePkg::dmemWords; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (ctrl.memWrite)
    begin
      mem[dAddr] <= rs2Data;
    end
  end

  assign loadData = mem[dAddr];

endmodule

//--- design/execUnit.sv
// ALU and branch-taken decision
`timescale 1ns/1ps

module execUnit (
  input  corePkg::wordT rs1Data,
  input  corePkg::wordT rs2Data,
  input  corePkg::wordT imm,
  input  corePkg::ctrlT ctrl,
  output corePkg::wordT aluResult,
  output logic          branchTaken
);

  corePkg::wordT opB;
  logic eq;
  logic lt;

  assign opB = ctrl.aluSrcImm ? imm : rs2Data;

  // Branches compare the register operands, signed
  assign eq = (rs1Data == rs2Data);
  assign lt = ($signed(rs1Data) < $signed(rs2Data));

  always_comb
  begin
    case (ctrl.aluOp)
      corePkg::aluAnd: aluResult = rs1Data & opB;
      corePkg::aluOr:  aluResult = rs1Data | opB;
      corePkg::aluAdd: aluResult = rs1Data + opB;
      corePkg::aluSub: aluResult = rs1Data - opB;
      default:         aluResult = '0;
    endcase
  end

  always_comb
  begin
    case (ctrl.branch)
      corePkg::brEq: branchTaken = eq;
      corePkg::brLt: branchTaken = lt;
      corePkg::brGe: branchTaken = !lt;
      default:       branchTaken = 1'b0;
    endcase
  end

endmodule

//--- design/fetchUnit.sv
// Program counter, loadable instruction memory and next-PC selection
`timescale 1ns/1ps

module fetchUnit (
  input  logic               clk,
  input  logic               reset,
  input  corePkg::progWriteT progWrite,
  input  corePkg::wordT      imm,
  input  logic               branchTaken,
  output corePkg::wordT      pc,
  output corePkg::instrT     instr
);

  corePkg::instrT imem [corePkg::imemWords];
  corePkg::wordT nextPc;
  corePkg::wordT pcPlus4;
  corePkg::wordT branchTarget;

  assign pcPlus4 = pc + 64'd4;
  assign branchTarget = pc + imm;  // B offset already shifted
  assign nextPc = branchTaken ? branchTarget : pcPlus4;

  // Program load port
  always_ff @(posedge clk)
  begin
    if (progWrite.valid)
    begin
      imem[progWrite.wordAddr] <= progWrite.instr;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc <= '0;
    end
    else
    begin
      pc <= nextPc;
    end
  end

  // Word index wraps over 64 entries
  assign instr = imem[pc[corePkg::imemAddrW+1:2]];

endmodule

//--- design/instrDecoder.sv
// Instruction field split, main control, ALU control and immediate generation
`timescale 1ns/1ps

module instrDecoder (
  input  corePkg::instrT               instr,
  output corePkg::ctrlT                ctrl,
  output corePkg::wordT                imm,
  output logic [corePkg::regAddrW-1:0] rs1,
  output logic [corePkg::regAddrW-1:0] rs2,
  output logic [corePkg::regAddrW-1:0] rd
);

  corePkg::opcodeE opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic rValid;
  corePkg::aluOpE rAluOp;

  assign opcode = corePkg::opcodeE'(instr[6:0]);
  assign rd = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign funct7 = instr[31:25];

  // ALU control for R-type
  always_comb
  begin
    rValid = 1'b1;
    rAluOp = corePkg::aluAdd;
    case (funct3)
      3'b000: rAluOp = funct7[5] ? corePkg::aluSub : corePkg::aluAdd;
      3'b111: rAluOp = corePkg::aluAnd;
      3'b110: rAluOp = corePkg::aluOr;
      default: rValid = 1'b0;
    endcase
  end

  // Main control, anything not matched stays a no-op
  always_comb
  begin
    ctrl = '0;
    case (opcode)
      corePkg::opR:
      begin
        ctrl.regWrite = rValid;
        ctrl.aluOp = rValid ? rAluOp : corePkg::aluAnd;
      end
      corePkg::opImm:
      begin
        if (funct3 == 3'b000)  // addi
        begin
          ctrl.regWrite = 1'b1;
          ctrl.aluSrcImm = 1'b1;
          ctrl.aluOp = corePkg::aluAdd;
        end
      end
      corePkg::opLoad:
      begin
        if (funct3 == 3'b011)  // ld
        begin
          ctrl.regWrite = 1'b1;
          ctrl.memToReg = 1'b1;
          ctrl.aluSrcImm = 1'b1;
          ctrl.aluOp = corePkg::aluAdd;
        end
      end
      corePkg::opStore:
      begin
        if (funct3 == 3'b011)  // sd
        begin
          ctrl.memWrite = 1'b1;
          ctrl.aluSrcImm = 1'b1;
          ctrl.aluOp = corePkg::aluAdd;
        end
      end
      corePkg::opBranch:
      begin
        case (funct3)
          3'b000: ctrl.branch = corePkg::brEq;
          3'b100: ctrl.branch = corePkg::brLt;
          3'b101: ctrl.branch = corePkg::brGe;
          default: ctrl.branch = corePkg::brNone;
        endcase
      end
      default: ctrl = '0;
    endcase
  end

  always_comb
  begin
    case (opcode)
      corePkg::opStore:
        imm = {{(corePkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
      corePkg::opBranch:
        imm = {{(corePkg::xlen-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      default:
        imm = {{(corePkg::xlen-12){instr[31]}}, instr[31:20]};  // I-type
    endcase
  end

endmodule

//--- design/regFile.sv
// 32 x 64 register file with x0 held at zero and reset clearing
`timescale 1ns/1ps

module regFile (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [corePkg::regAddrW-1:0] rs1,
  input  logic [corePkg::regAddrW-1:0] rs2,
  input  logic [corePkg::regAddrW-1:0] rd,
  input  corePkg::ctrlT                ctrl,
  input  corePkg::wordT                aluResult,
  input  corePkg::wordT                loadData,
  output corePkg::wordT                rs1Data,
  output corePkg::wordT                rs2Data
);

  corePkg::wordT regs [2**corePkg::regAddrW];
  corePkg::wordT writeData;

  assign writeData = ctrl.memToReg ? loadData : aluResult;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < 2**corePkg::regAddrW; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (ctrl.regWrite && (rd != '0))  // x0 never written
    begin
      regs[rd] <= writeData;
    end
  end

  assign rs1Data = regs[rs1];
  assign rs2Data = regs[rs2];

endmodule

//--- design/riscCore.sv
// Single-cycle RV64 subset core top level with retire trace assembly
`timescale 1ns/1ps

module riscCore (
  input  logic               clk,
  input  logic               reset,
  input  corePkg::progWriteT progWrite,
  output corePkg::retireT    retire
);

  corePkg::wordT pc;
  corePkg::instrT instr;
  corePkg::ctrlT ctrl;
  corePkg::wordT imm;
  logic [corePkg::regAddrW-1:0] rs1;
  logic [corePkg::regAddrW-1:0] rs2;
  logic [corePkg::regAddrW-1:0] rd;
  corePkg::wordT rs1Data;
  corePkg::wordT rs2Data;
  corePkg::wordT aluResult;
  corePkg::wordT loadData;
  logic branchTaken;

  fetchUnit u_fetchUnit (.clk(clk), .reset(reset), .progWrite(progWrite), .imm(imm),
    .branchTaken(branchTaken), .pc(pc), .instr(instr));

  instrDecoder u_instrDecoder (.instr(instr), .ctrl(ctrl), .imm(imm), .rs1(rs1), .rs2(rs2),
    .rd(rd));

  regFile u_regFile (.clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd), .ctrl(ctrl),
    .aluResult(aluResult), .loadData(loadData), .rs1Data(rs1Data), .rs2Data(rs2Data));

  execUnit u_execUnit (.rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .ctrl(ctrl),
    .aluResult(aluResult), .branchTaken(branchTaken));

  dataMemory u_dataMemory (.clk(clk), .reset(reset), .aluResult(aluResult), .rs2Data(rs2Data),
    .ctrl(ctrl), .loadData(loadData));

  // Instruction at pc retires this cycle
  assign retire.valid = !reset;
  assign retire.pc = pc;
  assign retire.rdWrite = ctrl.regWrite && (rd != '0);  // Writes to x0 are dropped
  assign retire.rd = rd;
  assign retire.rdData = ctrl.memToReg ? loadData : aluResult;
  assign retire.store = ctrl.memWrite;
  assign retire.storeAddr = aluResult[corePkg::dmemAddrW+2:3];
  assign retire.storeData = rs2Data;

endmodule

//--- riscCore.f
design/corePkg.sv
design/fetchUnit.sv
design/instrDecoder.sv
design/regFile.sv
design/execUnit.sv
design/dataMemory.sv
design/riscCore.sv
test/riscCore_chk.sv
test/riscCoreTb.sv

//--- test/riscCoreTb.sv
// Testbench with random programs, ISA reference model, retire trace checks and watchdog
`timescale 1ns/1ps

module riscCoreTb;

  localparam int numPrograms = 20;
  localparam int resetCycles = 8;
  localparam int runCycles = 150;
  localparam int clkPeriod = 10;
  localparam int watchdogNs =
    numPrograms * (runCycles + resetCycles + corePkg::imemWords) * clkPeriod * 2;

  logic clk;
  logic reset;
  corePkg::progWriteT progWrite;
  corePkg::retireT retire;

  corePkg::instrT mImem [corePkg::imemWords];  // Model copy of the program
  corePkg::wordT mRegs [2**corePkg::regAddrW];
  corePkg::wordT mDmem [corePkg::dmemWords];
  corePkg::wordT mPc;
  int errorCount;
  int unsigned seedDummy;

  riscCore u_riscCore (.clk(clk), .reset(reset), .progWrite(progWrite), .retire(retire));

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial
  begin
    #(watchdogNs);
    $display("Watchdog timeout, the run did not finish in time");
    $display("Verification failed");
    $finish;
  end

  task automatic nextDrive();
    @(posedge clk);
    #1;
  endtask

  task automatic checkField(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      errorCount++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One random instruction from the kept set, about 5% unknown opcodes
  function automatic corePkg::instrT randomInstr();
    int kind;
    int v;
    logic [11:0] imm12;
    logic [12:0] off;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [6:0] op;
    logic [31:0] bits;
    kind = $urandom_range(0, 99);
    rd = 5'($urandom_range(0, 31));
    rs1 = 5'($urandom_range(0, 31));
    rs2 = 5'($urandom_range(0, 31));
    v = int'($urandom_range(0, 255)) - 128;
    imm12 = v[11:0];
    v = (int'($urandom_range(0, 16)) - 8) * 4;  // Word-aligned branch offset
    off = v[12:0];
    if (kind < 5)
    begin
      do
      begin
        op = 7'($urandom_range(0, 127));
      end
      while (op == corePkg::opR || op == corePkg::opImm || op == corePkg::opLoad ||
             op == corePkg::opStore || op == corePkg::opBranch);
      bits = $urandom();
      return {bits[31:7], op};
    end
    case ($urandom_range(0, 9))
      0: return {7'b0000000, rs2, rs1, 3'b000, rd, corePkg::opR};  // add
      1: return {7'b0100000, rs2, rs1, 3'b000, rd, corePkg::opR};  // sub
      2: return {7'b0000000, rs2, rs1, 3'b111, rd, corePkg::opR};  // and
      3: return {7'b0000000, rs2, rs1, 3'b110, rd, corePkg::opR};  // or
      4: return {imm12, rs1, 3'b000, rd, corePkg::opImm};
      5: return {imm12, rs1, 3'b011, rd, corePkg::opLoad};
      6: return {imm12[11:5], rs2, rs1, 3'b011, imm12[4:0], corePkg::opStore};
      7: return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], corePkg::opBranch};
      8: return {off[12], off[10:5], rs2, rs1, 3'b100, off[4:1], off[11], corePkg::opBranch};
      default: return {off[12], off[10:5], rs2, rs1, 3'b101, off[4:1], off[11], corePkg::opBranch};
    endcase
  endfunction

  task automatic clearModel();
    mPc = '0;
    foreach (mRegs[i]) mRegs[i] = '0;
    foreach (mDmem[i]) mDmem[i] = '0;
  endtask

  // Predict the retire record at mPc, compare, then apply the clock edge effects
  task automatic checkAndStep();
    corePkg::instrT ins;
    logic [2:0] f3;
    logic [4:0] rd;
    corePkg::wordT a;
    corePkg::wordT b;
    corePkg::wordT immI;
    corePkg::wordT immS;
    corePkg::wordT immB;
    corePkg::wordT res;
    corePkg::wordT addr;
    corePkg::wordT nextPc;
    logic expWrite;
    logic expStore;
    logic taken;
    ins = mImem[mPc[7:2]];
    f3 = ins[14:12];
    rd = ins[11:7];
    a = mRegs[ins[19:15]];
    b = mRegs[ins[24:20]];
    immI = {{52{ins[31]}}, ins[31:20]};
    immS = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    immB = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    res = '0;
    addr = '0;
    expWrite = 1'b0;
    expStore = 1'b0;
    taken = 1'b0;
    case (ins[6:0])
      corePkg::opR:
      begin
        expWrite = (f3 == 3'b000) || (f3 == 3'b111) || (f3 == 3'b110);
        if (f3 == 3'b000) res = ins[30] ? a - b : a + b;
        if (f3 == 3'b111) res = a & b;
        if (f3 == 3'b110) res = a | b;
      end
      corePkg::opImm:
      begin
        expWrite = (f3 == 3'b000);
        res = a + immI;
      end
      corePkg::opLoad:
      begin
        expWrite = (f3 == 3'b011);
        addr = a + immI;
        res = mDmem[addr[7:3]];
      end
      corePkg::opStore:
      begin
        expStore = (f3 == 3'b011);
        addr = a + immS;
      end
      corePkg::opBranch:
      begin
        if (f3 == 3'b000) taken = (a == b);
        if (f3 == 3'b100) taken = ($signed(a) < $signed(b));
        if (f3 == 3'b101) taken = ($signed(a) >= $signed(b));
      end
      default: ;
    endcase
    expWrite = expWrite && (rd != 5'd0);  // x0 ignores writes
    nextPc = taken ? mPc + immB : mPc + 64'd4;
    checkField("retire.valid", 64'(retire.valid), 64'd1);
    checkField("retire.pc", retire.pc, mPc);
    checkField("retire.rdWrite", 64'(retire.rdWrite), 64'(expWrite));
    if (expWrite)
    begin
      checkField("retire.rd", 64'(retire.rd), 64'(rd));
      checkField("retire.rdData", retire.rdData, res);
      mRegs[rd] = res;
    end
    checkField("retire.store", 64'(retire.store), 64'(expStore));
    if (expStore)
    begin
      checkField("retire.storeAddr", 64'(retire.storeAddr), 64'(addr[7:3]));
      checkField("retire.storeData", retire.storeData, b);
      mDmem[addr[7:3]] = b;
    end
    mPc = nextPc;
  endtask

  task automatic runProgram();
    nextDrive();
    reset = 1'b1;
    repeat (resetCycles) nextDrive();
    for (int i = 0; i < corePkg::imemWords; i++)
    begin
      mImem[i] = randomInstr();
      progWrite.valid = 1'b1;
      progWrite.wordAddr = i[corePkg::imemAddrW-1:0];
      progWrite.instr = mImem[i];
      nextDrive();
    end
    progWrite = '0;
    reset = 1'b0;
    clearModel();
    for (int c = 0; c < runCycles; c++)
    begin
      @(negedge clk);  // Retire record settled mid-cycle
      checkAndStep();
    end
  endtask

  initial
  begin
    seedDummy = $urandom(32'h1062ad5f);
    errorCount = 0;
    reset = 1'b1;
    progWrite = '0;
    for (int p = 0; p < numPrograms; p++)
    begin
      runProgram();
    end
    $display("Programs run: %0d, errors: %0d", numPrograms, errorCount);
    if (errorCount == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- test/riscCore_chk.sv
// Concurrent assertions on the riscCore retire port, bound to the core
`timescale 1ns/1ps

module riscCoreChk (
  input logic            clk,
  input logic            reset,
  input corePkg::retireT retire
);

  // Reset also holds the PC at zero
  noRetireInReset: assert property (@(posedge clk)
    reset |-> (!retire.valid && (retire.pc == '0)))
    else $error("retire.valid high or retire.pc nonzero while reset is held");

  // Fetch only ever sees word addresses
  pcAligned: assert property (@(posedge clk) disable iff (reset)
    retire.pc[1:0] == 2'b00)
    else $error("retire.pc not word aligned");

  writeOrStore: assert property (@(posedge clk) disable iff (reset)
    !(retire.rdWrite && retire.store))
    else $error("rdWrite and store high in the same cycle");

endmodule

bind riscCore riscCoreChk u_riscCoreChk (.clk(clk), .reset(reset), .retire(retire));
